// ==== verilog.f ====
+incdir+source
source/panel_pkg.sv
source/panel_fsm.sv
source/master_setup_regs.sv
source/write_data_bank.sv
source/config_sequencer.sv
source/launch_control.sv
source/bus_panel_top.sv
testbench/bus_panel_tb.sv

// ==== Bender.yml ====
package:
  name: bus_panel

sources:
  - include_dirs:
      - source
    files:
      - source/panel_pkg.sv
      - source/panel_fsm.sv
      - source/master_setup_regs.sv
      - source/write_data_bank.sv
      - source/config_sequencer.sv
      - source/launch_control.sv
      - source/bus_panel_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/bus_panel_tb.sv

// ==== testbench/bus_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module bus_panel_tb;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 8;
    localparam int slave_m0     = 1;
    localparam int slave_m1     = 3;   // the small slave, so its length clamps
    localparam int entry_len    = 40;  // operator steps and bank words
    localparam int cfg_len      = `MASTER_COUNT * `CFG_PHASE_CYCLES * (`BANK_DEPTH + 2);
    localparam int run_len      = 2 * (2 * reset_cycles + entry_len + cfg_len + `START_DELAY + 30);
    localparam logic [`MASTER_COUNT-1:0] first_bit  = 1 << `FIRST_MASTER;
    localparam logic [`MASTER_COUNT-1:0] second_bit = 1 << (`MASTER_COUNT - 1 - `FIRST_MASTER);

    logic                     clk;
    logic                     rstN;
    logic [17:0]              sw;
    logic                     step_n;
    logic                     next_n;
    logic [`MASTER_COUNT-1:0] done_com;
    panel_pkg::master_cmd_t   master_cmd [`MASTER_COUNT];
    logic [3:0]               status_led;

    logic [`MASTER_COUNT-1:0] start_vec;
    logic [`MASTER_COUNT-1:0] eoc_vec;
    logic [7:0]               cfg_count [`MASTER_COUNT];  // config starts seen per master
    logic                     chk_idle;
    logic                     expect_eoc;
    logic                     cfg_window;
    logic                     launch_window;
    logic                     launch_step;
    logic                     comm_hold;
    logic                     done_set;
    logic                     addr_check;

    panel_pkg::addr_t         first_addr [`MASTER_COUNT];
    panel_pkg::addr_t         exp_last [`MASTER_COUNT];
    logic [$bits(panel_pkg::slave_id_t)+2:0] exp_flags [`MASTER_COUNT];  // slave, dir, src, burst
    panel_pkg::data_t         words [3];
    panel_pkg::addr_t         exp_rb;
    int                       errors;
    int                       tests_run;
    int                       errors_before;

    bus_panel_top bus_panel_top_inst (
        .clk, .rstN, .sw, .step_n, .next_n, .done_com, .master_cmd, .status_led
    );

    always #(clk_period / 2) clk = ~clk;

    always_comb begin
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            start_vec[i] = master_cmd[i].start;
            eoc_vec[i]   = master_cmd[i].eoc;
        end
    end

    always @(posedge clk) begin
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            if (cfg_window && start_vec[i]) begin
                cfg_count[i] <= cfg_count[i] + 8'd1;
            end
        end
    end

    // last address is first plus length, held inside the slave
    function automatic panel_pkg::addr_t expected_last(input int first, input int len,
                                                       input int slave);
        int depth;
        int sum;
        case (slave)
            2:       depth = `SLAVE2_DEPTH;
            3:       depth = `SLAVE3_DEPTH;
            default: depth = `SLAVE1_DEPTH;
        endcase
        sum = first + len;
        return panel_pkg::addr_t'((sum > depth - 1) ? depth - 1 : sum);
    endfunction

    task automatic log_mismatch(input string test, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
        $display("Mismatch %s %s: expected %h actual %h", test, what, exp, act);
        errors++;
    endtask

    task automatic count_failure(input string test, input string msg);
        $display("Error in %s: %s", test, msg);
        errors++;
    endtask

    task automatic step_once();
        step_n = 1'b0;
        @(negedge clk);
        step_n = 1'b1;
        @(negedge clk);
    endtask

    task automatic press_next(input panel_pkg::data_t word);
        sw     = 18'(word);
        next_n = 1'b0;
        @(negedge clk);
        next_n = 1'b1;
        @(negedge clk);
    endtask

    task automatic wait_for_led(input int idx, input int limit);
        int n;
        n = 0;
        while (!status_led[idx] && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!status_led[idx]) begin
            count_failure("wait", $sformatf("status light %0d never came on", idx));
        end
    endtask

    task automatic apply_reset();
        rstN = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("test %0d %s finished, %0d errors", tests_run, name, errors - errors_before);
        errors_before = errors;
    endtask

    assert property (@(posedge clk) disable iff (!rstN) chk_idle |-> status_led == 4'b0001)
        else log_mismatch("reset_idle", "status", 4'b0001, $sampled(status_led));
    assert property (@(posedge clk) disable iff (!rstN)
        !cfg_window && !launch_window |-> start_vec == '0)
        else log_mismatch("any", "stray start", 0, $sampled(start_vec));
    assert property (@(posedge clk) disable iff (!rstN) !expect_eoc |-> eoc_vec == '0)
        else log_mismatch("any", "stray eoc", 0, $sampled(eoc_vec));
    assert property (@(posedge clk) disable iff (!rstN) expect_eoc |-> eoc_vec == '1)
        else log_mismatch("no_slave", "eoc", 2'b11, $sampled(eoc_vec));
    assert property (@(posedge clk) disable iff (!rstN) expect_eoc |=> status_led == 4'b0100)
        else log_mismatch("no_slave", "status", 4'b0100, $sampled(status_led));

    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[0] && cfg_count[0] == 0 |->
            {master_cmd[0].address, master_cmd[0].data} == {first_addr[0], words[0]})
        else log_mismatch("config_m0", "first addr/data", {first_addr[0], words[0]},
            {$sampled(master_cmd[0].address), $sampled(master_cmd[0].data)});
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[0] && cfg_count[0] == 1 |->
            {master_cmd[0].address, master_cmd[0].data} == {exp_last[0], words[2]})
        else log_mismatch("config_m0", "last addr/data", {exp_last[0], words[2]},
            {$sampled(master_cmd[0].address), $sampled(master_cmd[0].data)});
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[1] |-> cfg_count[0] == 2)
        else count_failure("config_m0", "master 1 configured before master 0 finished");
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[1] && cfg_count[1] == 0 |-> master_cmd[1].address == first_addr[1])
        else log_mismatch("clamp_m1", "first addr", first_addr[1],
            $sampled(master_cmd[1].address));
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[1] && cfg_count[1] == 1 |-> master_cmd[1].address == exp_last[1])
        else log_mismatch("clamp_m1", "last addr", exp_last[1], $sampled(master_cmd[1].address));
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[0] |-> {master_cmd[0].slave_id, master_cmd[0].rd_wr,
            master_cmd[0].in_ex, master_cmd[0].burst} == exp_flags[0])
        else log_mismatch("config_m0", "setup flags", exp_flags[0],
            {$sampled(master_cmd[0].slave_id), $sampled(master_cmd[0].rd_wr),
             $sampled(master_cmd[0].in_ex), $sampled(master_cmd[0].burst)});
    assert property (@(posedge clk) disable iff (!rstN)
        cfg_window && start_vec[1] |-> {master_cmd[1].slave_id, master_cmd[1].rd_wr,
            master_cmd[1].in_ex, master_cmd[1].burst} == exp_flags[1])
        else log_mismatch("clamp_m1", "setup flags", exp_flags[1],
            {$sampled(master_cmd[1].slave_id), $sampled(master_cmd[1].rd_wr),
             $sampled(master_cmd[1].in_ex), $sampled(master_cmd[1].burst)});
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(status_led[1]) |-> cfg_count[0] == 2 && cfg_count[1] == 2)
        else log_mismatch("config_m0", "config starts", 16'h0202,
            {$sampled(cfg_count[1]), $sampled(cfg_count[0])});

    if (`START_DELAY == 0) begin : g_launch_same
        assert property (@(posedge clk) disable iff (!rstN) launch_step |=> start_vec == '1)
            else log_mismatch("launch", "start pulses", 2'b11, $sampled(start_vec));
    end else begin : g_launch_stagger
        assert property (@(posedge clk) disable iff (!rstN)
            launch_step |=> start_vec == first_bit ##(`START_DELAY + 1) start_vec == second_bit)
            else count_failure("launch", "start pulses not staggered by the start delay");
    end
    assert property (@(posedge clk) disable iff (!rstN) launch_step |=> status_led == 4'b1000)
        else log_mismatch("launch", "status", 4'b1000, $sampled(status_led));
    assert property (@(posedge clk) disable iff (!rstN) comm_hold |-> status_led == 4'b1000)
        else log_mismatch("readback", "status early", 4'b1000, $sampled(status_led));
    assert property (@(posedge clk) disable iff (!rstN) done_set |=> status_led == 4'b0100)
        else log_mismatch("readback", "status", 4'b0100, $sampled(status_led));
    assert property (@(posedge clk) disable iff (!rstN)
        addr_check |-> master_cmd[0].address == exp_rb && master_cmd[1].address == exp_rb)
        else log_mismatch("readback", "address", {exp_rb, exp_rb},
            {$sampled(master_cmd[1].address), $sampled(master_cmd[0].address)});

    initial begin
        repeat (run_len) @(posedge clk);
        $display("watchdog expired after %0d cycles", run_len);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int len0;
        int len1;
        clk           = 1'b0;
        rstN          = 1'b0;
        sw            = '0;
        step_n        = 1'b1;
        next_n        = 1'b1;
        done_com      = '0;
        chk_idle      = 1'b0;
        expect_eoc    = 1'b0;
        cfg_window    = 1'b0;
        launch_window = 1'b0;
        launch_step   = 1'b0;
        comm_hold     = 1'b0;
        done_set      = 1'b0;
        addr_check    = 1'b0;
        errors        = 0;
        tests_run     = 0;
        errors_before = 0;
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            cfg_count[i] = '0;
        end
        void'($urandom(32'h86b2));

        apply_reset();
        chk_idle = 1'b1;
        repeat (4) @(negedge clk);
        chk_idle = 1'b0;
        finish_test("reset_idle");

        sw         = '0;  // no slave for either master
        expect_eoc = 1'b1;
        step_n     = 1'b0;
        @(negedge clk);
        expect_eoc = 1'b0;
        step_n     = 1'b1;
        repeat (3) @(negedge clk);
        finish_test("no_slave");

        apply_reset();
        first_addr[0] = panel_pkg::addr_t'($urandom % 1024);
        first_addr[1] = panel_pkg::addr_t'(1024 + $urandom % 1024);
        len0          = int'($urandom % 1024);
        len1          = int'(2048 + $urandom % 2048);  // runs past slave 3
        exp_last[0]   = expected_last(int'(first_addr[0]), len0, slave_m0);
        exp_last[1]   = expected_last(int'(first_addr[1]), len1, slave_m1);
        exp_flags[0]  = {panel_pkg::slave_id_t'(slave_m0), 1'b0, 1'b1, 1'b1};  // three words
        exp_flags[1]  = {panel_pkg::slave_id_t'(slave_m1), 1'b1, 1'b0, 1'b0};
        sw = 18'(slave_m1 * 4 + slave_m0);
        step_once();
        sw = 18'b10;  // direction bit set for master 1 only
        step_once();
        sw = 18'b01;  // external data for master 0 only
        step_once();
        for (int k = 0; k < 3; k++) begin
            words[k] = panel_pkg::data_t'($urandom);
            press_next(words[k]);
        end
        step_once();
        sw = 18'(first_addr[0]);
        step_once();
        sw = 18'(first_addr[1]);
        step_once();
        sw = 18'(len0);
        step_once();
        sw         = 18'(len1);
        cfg_window = 1'b1;
        step_once();  // into configuring
        wait_for_led(1, cfg_len);
        cfg_window = 1'b0;
        finish_test("config_m0");
        finish_test("clamp_m1");

        launch_window = 1'b1;
        launch_step   = 1'b1;
        step_n        = 1'b0;
        @(negedge clk);
        launch_step = 1'b0;
        step_n      = 1'b1;
        repeat (`START_DELAY + 2) @(negedge clk);
        launch_window = 1'b0;
        finish_test("launch");

        comm_hold = 1'b1;
        done_com  = 2'b01;  // master 1 still busy
        repeat (2) @(negedge clk);
        comm_hold = 1'b0;
        done_com  = 2'b11;
        done_set  = 1'b1;
        @(negedge clk);
        done_set = 1'b0;
        @(negedge clk);
        exp_rb     = panel_pkg::addr_t'($urandom);
        sw         = 18'(exp_rb);
        addr_check = 1'b1;
        @(negedge clk);
        addr_check = 1'b0;
        @(negedge clk);
        finish_test("readback");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/bus_panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module bus_panel_top (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [17:0]               sw,
    input  logic                      step_n,
    input  logic                      next_n,
    input  logic [`MASTER_COUNT-1:0]  done_com,
    output panel_pkg::master_cmd_t    master_cmd [`MASTER_COUNT],
    output logic [3:0]                status_led
);

    panel_pkg::panel_phase_t  phase;
    panel_pkg::master_setup_t setup [`MASTER_COUNT];
    panel_pkg::master_cmd_t   cfg_cmd [`MASTER_COUNT];
    panel_pkg::master_idx_t   rd_master;
    panel_pkg::bank_ptr_t     rd_index;
    panel_pkg::data_t         rd_data;
    logic [`MASTER_COUNT-1:0] launch_start;
    logic                     cfg_done;
    logic                     no_slave_step;

    panel_fsm panel_fsm_inst (
        .clk, .rstN, .sw, .step_n, .setup, .cfg_done, .done_com, .phase, .status_led
    );

    master_setup_regs master_setup_regs_inst (
        .clk, .rstN, .phase, .sw, .step_n, .next_n, .setup
    );

    write_data_bank write_data_bank_inst (
        .clk, .rstN, .phase, .sw, .step_n, .next_n, .rd_master, .rd_index, .rd_data
    );

    config_sequencer config_sequencer_inst (
        .clk, .rstN, .phase, .setup, .rd_data, .rd_master, .rd_index, .cfg_cmd, .cfg_done
    );

    launch_control launch_control_inst (
        .clk, .rstN, .phase, .step_n, .launch_start
    );

    // nothing selected, so both masters skip to their end state
    assign no_slave_step = (phase == panel_pkg::slave_sel) && !step_n && (sw[3:0] == '0);

    always_comb begin
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            master_cmd[i].start    = cfg_cmd[i].start | launch_start[i];  // never in one phase
            master_cmd[i].eoc      = no_slave_step;
            master_cmd[i].rd_wr    = setup[i].rd_wr;
            master_cmd[i].in_ex    = setup[i].in_ex;
            master_cmd[i].burst    = setup[i].burst;
            master_cmd[i].slave_id = setup[i].slave_id;
            master_cmd[i].address  = (phase == panel_pkg::done) ? sw[`ADDR_WIDTH-1:0]
                                                                : cfg_cmd[i].address;
            master_cmd[i].data     = cfg_cmd[i].data;
        end
    end

endmodule

`default_nettype wire

// ==== source/launch_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module launch_control (
    input  logic                      clk,
    input  logic                      rstN,
    input  panel_pkg::panel_phase_t   phase,
    input  logic                      step_n,
    output logic [`MASTER_COUNT-1:0]  launch_start
);

    localparam int first  = `FIRST_MASTER;
    localparam int second = `MASTER_COUNT - 1 - `FIRST_MASTER;
    localparam int dly_w  = $clog2(`START_DELAY + 2);

    logic [dly_w-1:0]         dly_cnt;
    logic [`MASTER_COUNT-1:0] launched;  // masters started since reset
    logic                     pending;
    logic                     go;

    assign go = (phase == panel_pkg::ready) && !step_n;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            launch_start <= '0;
            launched     <= '0;
            dly_cnt      <= '0;
            pending      <= 1'b0;
        end else begin
            launch_start <= '0;
            launched     <= launched | launch_start;
            if (go) begin
                dly_cnt <= '0;
                if (`START_DELAY == 0) begin
                    launch_start <= '1;
                end else begin
                    launch_start[first] <= 1'b1;
                    pending             <= 1'b1;
                end
            end else if (pending) begin
                dly_cnt <= dly_cnt + 1'b1;
                if (dly_cnt == dly_w'(`START_DELAY)) begin
                    launch_start[second] <= 1'b1;  // stagger elapsed
                    pending              <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) (launch_start & launched) == '0)
        else $error("master launched twice in one run");

    assert property (@(posedge clk) disable iff (!rstN)
        launch_start[first] |-> ##[1:`START_DELAY + 2] (&launched))
        else $error("second master never launched");

endmodule

`default_nettype wire

// ==== source/config_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module config_sequencer (
    input  logic                      clk,
    input  logic                      rstN,
    input  panel_pkg::panel_phase_t   phase,
    input  panel_pkg::master_setup_t  setup [`MASTER_COUNT],
    input  panel_pkg::data_t          rd_data,
    output panel_pkg::master_idx_t    rd_master,
    output panel_pkg::bank_ptr_t      rd_index,
    output panel_pkg::master_cmd_t    cfg_cmd [`MASTER_COUNT],
    output logic                      cfg_done
);

    localparam int cnt_w = $clog2(`CFG_PHASE_CYCLES + 1);

    panel_pkg::cfg_phase_t    state;
    panel_pkg::bank_ptr_t     word;
    panel_pkg::master_idx_t   m;
    panel_pkg::master_setup_t cur;
    logic [cnt_w-1:0]         cnt;
    logic                     active;
    logic                     last_cycle;
    logic                     has_middle;

    assign active     = (phase == panel_pkg::configuring);
    assign cur        = setup[m];
    assign last_cycle = (cnt == cnt_w'(`CFG_PHASE_CYCLES - 1));
    // middle only when words sit between the first and the last
    assign has_middle = cur.in_ex && (cur.write_count > panel_pkg::bank_ptr_t'(2));
    assign rd_master  = m;
    assign rd_index   = word;
    assign cfg_done   = active && (state == panel_pkg::cfg_done);  // drops as phase moves on

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= panel_pkg::cfg_first;
            cnt   <= '0;
            word  <= '0;
            m     <= '0;
        end else if (!active) begin
            state <= panel_pkg::cfg_first;  // rearm for master 0
            cnt   <= '0;
            word  <= '0;
            m     <= '0;
        end else if (state != panel_pkg::cfg_done) begin
            cnt <= last_cycle ? '0 : cnt + 1'b1;
            if (last_cycle) begin
                case (state)
                    panel_pkg::cfg_first: begin
                        word  <= word + 1'b1;
                        state <= has_middle ? panel_pkg::cfg_middle : panel_pkg::cfg_last;
                    end
                    panel_pkg::cfg_middle: begin
                        word <= word + 1'b1;
                        if (word == cur.write_count - panel_pkg::bank_ptr_t'(2)) begin
                            state <= panel_pkg::cfg_last;
                        end
                    end
                    default: begin
                        word <= '0;
                        if (m == panel_pkg::master_idx_t'(`MASTER_COUNT - 1)) begin
                            state <= panel_pkg::cfg_done;
                        end else begin
                            m     <= m + 1'b1;
                            state <= panel_pkg::cfg_first;
                        end
                    end
                endcase
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            cfg_cmd[i] = '0;
            if (active && state != panel_pkg::cfg_done && m == panel_pkg::master_idx_t'(i)) begin
                cfg_cmd[i].start   = (state != panel_pkg::cfg_middle) && (cnt == '0);
                cfg_cmd[i].address = (state == panel_pkg::cfg_first) ? cur.first_addr
                                                                      : cur.last_addr;
                cfg_cmd[i].data    = rd_data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) cfg_done |=> !cfg_done)
        else $error("config done held for more than one cycle");

endmodule

`default_nettype wire

// ==== source/write_data_bank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module write_data_bank (
    input  logic                     clk,
    input  logic                     rstN,
    input  panel_pkg::panel_phase_t  phase,
    input  logic [17:0]              sw,
    input  logic                     step_n,
    input  logic                     next_n,
    input  panel_pkg::master_idx_t   rd_master,
    input  panel_pkg::bank_ptr_t     rd_index,
    output panel_pkg::data_t         rd_data
);

    panel_pkg::data_t       mem [`MASTER_COUNT][`BANK_DEPTH];
    panel_pkg::bank_ptr_t   ptr;
    panel_pkg::master_idx_t wr_master;
    logic                   writing;

    assign writing = phase inside
        {panel_pkg::write_m0, panel_pkg::write_m1, panel_pkg::write_both};
    assign wr_master = panel_pkg::master_idx_t'(phase == panel_pkg::write_m1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ptr <= '0;
        end else if (!step_n) begin
            ptr <= '0;  // each master's words start at 0
        end else if (writing && !next_n) begin
            ptr <= ptr + 1'b1;
        end
    end

    // the word under the pointer follows the switches until next
    always_ff @(posedge clk) begin
        if (writing) begin
            mem[wr_master][ptr] <= sw[`DATA_WIDTH-1:0];
        end
    end

    assign rd_data = mem[rd_master][rd_index];

endmodule

`default_nettype wire

// ==== source/master_setup_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module master_setup_regs (
    input  logic                      clk,
    input  logic                      rstN,
    input  panel_pkg::panel_phase_t   phase,
    input  logic [17:0]               sw,
    input  logic                      step_n,
    input  logic                      next_n,
    output panel_pkg::master_setup_t  setup [`MASTER_COUNT]
);

    localparam int id_w = $bits(panel_pkg::slave_id_t);

    typedef logic [`ADDR_WIDTH:0] span_t;  // one spare bit for the sum

    function automatic span_t depth_of(input panel_pkg::slave_id_t id);
        case (id)
            2:       depth_of = span_t'(`SLAVE2_DEPTH);
            3:       depth_of = span_t'(`SLAVE3_DEPTH);
            default: depth_of = span_t'(`SLAVE1_DEPTH);
        endcase
    endfunction

    panel_pkg::master_idx_t sel;
    panel_pkg::addr_t       last_calc;
    logic                   writing;
    span_t                  span;
    span_t                  limit;

    assign sel = panel_pkg::master_idx_t'(phase inside
        {panel_pkg::write_m1, panel_pkg::first_m1, panel_pkg::length_m1});
    assign writing = phase inside
        {panel_pkg::write_m0, panel_pkg::write_m1, panel_pkg::write_both};

    // length runs past the slave, so stop at its top word
    assign span      = span_t'(setup[sel].first_addr) + span_t'(sw[`ADDR_WIDTH-1:0]);
    assign limit     = depth_of(setup[sel].slave_id) - span_t'(1);
    assign last_calc = (span > limit) ? limit[`ADDR_WIDTH-1:0] : span[`ADDR_WIDTH-1:0];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MASTER_COUNT; i++) begin
                setup[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `MASTER_COUNT; i++) begin
                case (phase)
                    panel_pkg::slave_sel:  setup[i].slave_id <= sw[id_w*i +: id_w];
                    panel_pkg::dir_sel:    setup[i].rd_wr <= sw[i];
                    panel_pkg::source_sel: setup[i].in_ex <= sw[i];
                    default: ;
                endcase
            end
            if (writing && step_n && !next_n) begin
                setup[sel].write_count <= setup[sel].write_count + 1'b1;
                setup[sel].burst <= setup[sel].burst | (setup[sel].write_count != '0);
            end
            if (phase inside {panel_pkg::first_m0, panel_pkg::first_m1}) begin
                setup[sel].first_addr <= sw[`ADDR_WIDTH-1:0];
            end
            if (phase inside {panel_pkg::length_m0, panel_pkg::length_m1}) begin
                setup[sel].last_addr <= last_calc;
            end
        end
    end

    for (genvar g = 0; g < `MASTER_COUNT; g++) begin : g_depth_chk
        assert property (@(posedge clk) disable iff (!rstN)
            phase == panel_pkg::configuring |->
                span_t'(setup[g].last_addr) < depth_of(setup[g].slave_id))
            else $error("master %0d last address beyond slave", g);
    end

endmodule

`default_nettype wire

// ==== source/panel_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "panel_cfg.svh"

module panel_fsm (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [17:0]               sw,
    input  logic                      step_n,
    input  panel_pkg::master_setup_t  setup [`MASTER_COUNT],
    input  logic                      cfg_done,
    input  logic [`MASTER_COUNT-1:0]  done_com,
    output panel_pkg::panel_phase_t   phase,
    output logic [3:0]                status_led
);

    panel_pkg::panel_phase_t step_target;
    panel_pkg::panel_phase_t next_phase;
    logic                    all_done;

    always_comb begin
        all_done = 1'b1;
        for (int i = 0; i < `MASTER_COUNT; i++) begin
            if (setup[i].slave_id != '0 && !done_com[i]) begin
                all_done = 1'b0;  // an active master is still busy
            end
        end
    end

    // where a step strobe leads from each operator phase
    always_comb begin
        step_target = phase;
        case (phase)
            panel_pkg::slave_sel: begin
                step_target = (sw[3:0] == '0) ? panel_pkg::done : panel_pkg::dir_sel;
            end
            panel_pkg::dir_sel:    step_target = panel_pkg::source_sel;
            panel_pkg::source_sel: begin
                case (sw[1:0])
                    2'b01:   step_target = panel_pkg::write_m0;
                    2'b10:   step_target = panel_pkg::write_m1;
                    2'b11:   step_target = panel_pkg::write_both;
                    default: step_target = panel_pkg::first_m0;
                endcase
            end
            panel_pkg::write_m0:   step_target = panel_pkg::first_m0;
            panel_pkg::write_both: step_target = panel_pkg::write_m1;
            panel_pkg::write_m1:   step_target = panel_pkg::first_m0;
            panel_pkg::first_m0:   step_target = panel_pkg::first_m1;
            panel_pkg::first_m1:   step_target = panel_pkg::length_m0;
            panel_pkg::length_m0:  step_target = panel_pkg::length_m1;
            panel_pkg::length_m1:  step_target = panel_pkg::configuring;
            panel_pkg::ready:      step_target = panel_pkg::communicating;
            default:               step_target = phase;  // no step exit
        endcase
    end

    always_comb begin
        if (phase == panel_pkg::configuring) begin
            next_phase = cfg_done ? panel_pkg::ready : phase;
        end else if (phase == panel_pkg::communicating) begin
            next_phase = all_done ? panel_pkg::done : phase;
        end else begin
            next_phase = step_n ? phase : step_target;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= panel_pkg::slave_sel;
        end else begin
            phase <= next_phase;
        end
    end

    assign status_led[0] = (phase == panel_pkg::slave_sel);  // initial
    assign status_led[1] = (phase == panel_pkg::ready);
    assign status_led[2] = (phase == panel_pkg::done);
    assign status_led[3] = (phase == panel_pkg::communicating);

    // done is terminal until the next reset
    assert property (@(posedge clk) disable iff (!rstN)
        phase == panel_pkg::done |=> phase == panel_pkg::done)
        else $error("phase left done without reset");

endmodule

`default_nettype wire

// ==== source/panel_pkg.sv ====
`default_nettype none
`include "panel_cfg.svh"

package panel_pkg;

    typedef logic [`DATA_WIDTH-1:0]                data_t;
    typedef logic [`ADDR_WIDTH-1:0]                addr_t;
    typedef logic [$clog2(`SLAVE_COUNT + 1)-1:0]   slave_id_t;    // 0 means no slave
    typedef logic [$clog2(`BANK_DEPTH)-1:0]        bank_ptr_t;
    typedef logic [$clog2(`MASTER_COUNT)-1:0]      master_idx_t;

    typedef enum logic [3:0] {
        slave_sel, dir_sel, source_sel,
        write_m0, write_m1, write_both,
        first_m0, first_m1, length_m0, length_m1,
        configuring, ready, communicating, done
    } panel_phase_t;

    typedef enum logic [1:0] {
        cfg_first, cfg_middle, cfg_last, cfg_done
    } cfg_phase_t;

    typedef struct packed {
        logic       start;
        logic       eoc;          // skip straight to end of communication
        logic       rd_wr;
        logic       in_ex;        // take data from the external bank
        logic       burst;
        slave_id_t  slave_id;
        addr_t      address;
        data_t      data;
    } master_cmd_t;

    typedef struct packed {
        slave_id_t  slave_id;
        logic       rd_wr;
        logic       in_ex;
        logic       burst;
        addr_t      first_addr;
        addr_t      last_addr;
        bank_ptr_t  write_count;  // words entered through the bank
    } master_setup_t;

endpackage

`default_nettype wire

// ==== source/panel_cfg.svh ====
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

`define MASTER_COUNT      2     // internal bus masters
`define SLAVE_COUNT       3     // addressable slaves, id 0 is none
`define DATA_WIDTH        16
`define ADDR_WIDTH        12
`define BANK_DEPTH        16    // external words held per master

`define SLAVE1_DEPTH      4096
`define SLAVE2_DEPTH      4096
`define SLAVE3_DEPTH      2048

`define CFG_PHASE_CYCLES  2     // cycles spent in each config step
`define START_DELAY       0     // launch gap, 0 launches both together
`define FIRST_MASTER      0     // master launched first when staggered

`endif
